//--- design/mm_defs.svh
// Widths and register map of the accelerator; MM_WIDTH must be a power of two and at least 2
`ifndef MM_DEFS_SVH
`define MM_DEFS_SVH

// Number of lanes, one accumulator per output column
`define MM_WIDTH 4
// Lane index width
`define MM_LANE_W $clog2(`MM_WIDTH)

// Operand and accumulator widths
`define MM_DATA_W 16
`define MM_ACC_W 32

// Operand staging depth
`define MM_OP_DEPTH 4

// Register port geometry
`define MM_ADDR_W 2
`define MM_REG_W 32
`define MM_REG_CTRL 2'd0
`define MM_REG_DIMS 2'd1
`define MM_REG_STATUS 2'd2

`endif

//--- design/mm_pkg.sv
// Shared types of the accelerator; all data is unsigned and dims_t maps 1:1 onto the DIMS register
`default_nettype none

`include "mm_defs.svh"

package mm_pkg;

  // One operand scalar or weight
  typedef logic [`MM_DATA_W-1:0] data_t;

  // One accumulator or result word
  typedef logic [`MM_ACC_W-1:0] acc_t;

  // Weights for one k step, lane 0 in the low bits
  typedef data_t [`MM_WIDTH-1:0] w_vec_t;

  // All accumulators of one row
  typedef acc_t [`MM_WIDTH-1:0] acc_vec_t;

  // Operand word as it sits in the staging buffer
  typedef struct packed {
    data_t  x;
    w_vec_t w;
  } operand_t;

  // Job shape
  // m_rows first so k_len lands in bits 15:0
  typedef struct packed {
    logic [15:0] m_rows;
    logic [15:0] k_len;
  } dims_t;

  // Buffer status
  typedef struct packed {
    logic full;
    logic empty;
  } buf_flags_t;

endpackage

`default_nettype wire

//--- design/mm_fifo.sv
// Circular buffer without overflow or underflow protection; the user must never push when full
`timescale 1ns/1ps
`default_nettype none

module mm_fifo #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = 4
) (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               clear_i,
  input  wire logic               push_i,
  input  wire T                   data_i,
  input  wire logic               pop_i,
  output T                        data_o,
  output mm_pkg::buf_flags_t      flags_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  // Storage, no reset needed
  T mem_q [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_nxt;
  logic [PTR_W-1:0] rd_ptr_nxt;
  logic [CNT_W-1:0] count_q;

  // Pointers wrap at DEPTH, works for any depth
  assign wr_ptr_nxt = (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
  assign rd_ptr_nxt = (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= wr_ptr_nxt;
      if (pop_i) rd_ptr_q <= rd_ptr_nxt;
      // Occupancy only moves when exactly one side is active
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Head is always visible
  assign data_o = mem_q[rd_ptr_q];

  assign flags_o.full  = (count_q == CNT_W'(DEPTH));
  assign flags_o.empty = (count_q == '0);

endmodule

`default_nettype wire

//--- design/mm_cfg_regs.sv
// Register slave with single-cycle start and clear; DIMS must be written nonzero before start
`timescale 1ns/1ps
`default_nettype none

`include "mm_defs.svh"

module mm_cfg_regs (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  we_i,
  input  wire logic                  re_i,
  input  wire logic [`MM_ADDR_W-1:0] addr_i,
  input  wire logic [`MM_REG_W-1:0]  wdata_i,
  output logic [`MM_REG_W-1:0]       rdata_o,
  input  wire logic                  busy_i,
  input  wire logic                  done_i,
  output logic                       start_o,
  output logic                       clear_o,
  output mm_pkg::dims_t              dims_o,
  output logic                       evt_done_o
);

  import mm_pkg::*;

  logic                 wr_ctrl;
  logic                 wr_dims;
  dims_t                dims_q;
  logic                 done_q;
  logic [`MM_REG_W-1:0] rdata_q;

  // Write decode
  assign wr_ctrl = we_i && (addr_i == `MM_REG_CTRL);
  assign wr_dims = we_i && (addr_i == `MM_REG_DIMS);

  // Command bits act in the write cycle itself
  assign start_o = wr_ctrl && wdata_i[0];
  assign clear_o = wr_ctrl && wdata_i[1];

  // Job shape, held until rewritten
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dims_q <= '0;
    end else if (wr_dims) begin
      dims_q <= dims_t'(wdata_i);
    end
  end

  // Sticky done
  // start or clear wins over a coincident done
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else if (start_o || clear_o) begin
      done_q <= 1'b0;
    end else if (done_i) begin
      done_q <= 1'b1;
    end
  end

  // Read data registered, valid the cycle after re_i
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (re_i) begin
      case (addr_i)
        `MM_REG_DIMS:   rdata_q <= `MM_REG_W'(dims_q);
        `MM_REG_STATUS: rdata_q <= {{(`MM_REG_W - 2){1'b0}}, done_q, busy_i};
        // CTRL is write only
        default:        rdata_q <= '0;
      endcase
    end
  end

  assign rdata_o    = rdata_q;
  assign dims_o     = dims_q;
  assign evt_done_o = done_i;

endmodule

`default_nettype wire

//--- design/mm_ctrl.sv
// Job sequencer; no output back-pressure, so the consumer must take every z word on the cycle shown
`timescale 1ns/1ps
`default_nettype none

`include "mm_defs.svh"

module mm_ctrl (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 clear_i,
  input  wire logic                 start_i,
  input  wire mm_pkg::dims_t        dims_i,
  input  wire logic                 op_empty_i,
  input  wire logic                 pipe_busy_i,
  input  wire mm_pkg::buf_flags_t   out_flags_i,
  output logic                      op_pop_o,
  output logic                      first_o,
  output logic                      buf_push_o,
  output logic [`MM_LANE_W-1:0]     buf_lane_o,
  output logic                      buf_pop_o,
  output logic                      busy_o,
  output logic                      done_o
);

  localparam logic [`MM_LANE_W-1:0] LAST_LANE = `MM_LANE_W'(`MM_WIDTH - 1);

  typedef enum logic [2:0] {
    st_idle,
    st_starting,
    st_computing,
    st_buffering,
    st_storing,
    st_finished
  } state_e;

  state_e                  state_q;
  state_e                  state_d;
  logic [15:0]             k_cnt_q;
  logic [15:0]             k_cnt_d;
  logic [15:0]             row_cnt_q;
  logic [15:0]             row_cnt_d;
  logic [`MM_LANE_W-1:0]   lane_q;
  logic [`MM_LANE_W-1:0]   lane_d;

  // State and counters, clear returns everything to idle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= st_idle;
      k_cnt_q   <= '0;
      row_cnt_q <= '0;
      lane_q    <= '0;
    end else if (clear_i) begin
      state_q   <= st_idle;
      k_cnt_q   <= '0;
      row_cnt_q <= '0;
      lane_q    <= '0;
    end else begin
      state_q   <= state_d;
      k_cnt_q   <= k_cnt_d;
      row_cnt_q <= row_cnt_d;
      lane_q    <= lane_d;
    end
  end

  always_comb begin
    state_d    = state_q;
    k_cnt_d    = k_cnt_q;
    row_cnt_d  = row_cnt_q;
    lane_d     = lane_q;
    op_pop_o   = 1'b0;
    buf_push_o = 1'b0;
    buf_pop_o  = 1'b0;
    done_o     = 1'b0;

    case (state_q)
      st_idle: begin
        k_cnt_d   = '0;
        row_cnt_d = '0;
        lane_d    = '0;
        if (start_i) state_d = st_starting;
      end

      // Wait for the first operand of the job
      st_starting: begin
        if (!op_empty_i) state_d = st_computing;
      end

      st_computing: begin
        if (k_cnt_q != dims_i.k_len) begin
          // One pop per cycle whenever an operand is staged
          if (!op_empty_i) begin
            op_pop_o = 1'b1;
            k_cnt_d  = k_cnt_q + 16'd1;
          end
        end else if (!pipe_busy_i) begin
          // All products landed in the accumulators
          lane_d  = '0;
          state_d = st_buffering;
        end
      end

      // Copy one accumulator lane per cycle, lane 0 first
      st_buffering: begin
        buf_push_o = !out_flags_i.full;
        lane_d     = lane_q + 1'b1;
        if (lane_q == LAST_LANE) begin
          lane_d  = '0;
          state_d = st_storing;
        end
      end

      // Drain the output buffer to the stream
      st_storing: begin
        buf_pop_o = !out_flags_i.empty;
        lane_d    = lane_q + 1'b1;
        if (lane_q == LAST_LANE) begin
          lane_d  = '0;
          k_cnt_d = '0;
          if (row_cnt_q == dims_i.m_rows - 16'd1) begin
            state_d = st_finished;
          end else begin
            row_cnt_d = row_cnt_q + 16'd1;
            state_d   = st_computing;
          end
        end
      end

      // Single cycle done event, still busy
      st_finished: begin
        done_o  = 1'b1;
        state_d = st_idle;
      end

      default: state_d = st_idle;
    endcase
  end

  // k equal to 0 restarts the accumulators
  assign first_o    = op_pop_o && (k_cnt_q == '0);
  assign buf_lane_o = lane_q;
  assign busy_o     = (state_q != st_idle);

endmodule

`default_nettype wire

//--- design/mm_engine.sv
// Two-stage MAC of MM_WIDTH lanes; products and sums are truncated to MM_ACC_W bits, unsigned
`timescale 1ns/1ps
`default_nettype none

`include "mm_defs.svh"

module mm_engine (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              clear_i,
  input  wire logic              in_valid_i,
  input  wire logic              first_i,
  input  wire mm_pkg::data_t     x_i,
  input  wire mm_pkg::w_vec_t    w_i,
  output mm_pkg::acc_vec_t       acc_o,
  output logic                   pipe_busy_o
);

  import mm_pkg::*;

  // Stage one
  acc_vec_t prod_q;
  logic     s1_valid_q;
  logic     s1_first_q;

  // Stage two holds the running sums
  acc_vec_t acc_q;

  // Valid and first travel alongside the products
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_valid_q <= 1'b0;
      s1_first_q <= 1'b0;
    end else if (clear_i) begin
      s1_valid_q <= 1'b0;
      s1_first_q <= 1'b0;
    end else begin
      s1_valid_q <= in_valid_i;
      s1_first_q <= first_i;
    end
  end

  // Scalar x broadcast to every lane
  always_ff @(posedge clk_i) begin
    if (in_valid_i) begin
      for (int j = 0; j < `MM_WIDTH; j++) begin
        prod_q[j] <= acc_t'(x_i) * acc_t'(w_i[j]);
      end
    end
  end

  // Load on the first k step, accumulate after that
  always_ff @(posedge clk_i) begin
    if (s1_valid_q) begin
      for (int j = 0; j < `MM_WIDTH; j++) begin
        if (s1_first_q) begin
          acc_q[j] <= prod_q[j];
        end else begin
          acc_q[j] <= acc_q[j] + prod_q[j];
        end
      end
    end
  end

  assign acc_o = acc_q;

  // Only stage one can hold an item not yet summed
  assign pipe_busy_o = s1_valid_q;

endmodule

`default_nettype wire

//--- design/mm_top.sv
// Accelerator top; host may drive op_valid_i only while op_space_o is high, z stream has no stall
`timescale 1ns/1ps
`default_nettype none

`include "mm_defs.svh"

module mm_top (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire logic                  cfg_we_i,
  input  wire logic                  cfg_re_i,
  input  wire logic [`MM_ADDR_W-1:0] cfg_addr_i,
  input  wire logic [`MM_REG_W-1:0]  cfg_wdata_i,
  output logic [`MM_REG_W-1:0]       cfg_rdata_o,
  input  wire logic                  op_valid_i,
  input  wire mm_pkg::data_t         op_x_i,
  input  wire mm_pkg::w_vec_t        op_w_i,
  output logic                       op_space_o,
  output logic                       z_valid_o,
  output mm_pkg::acc_t               z_data_o,
  output logic                       busy_o,
  output logic                       evt_done_o
);

  import mm_pkg::*;

  logic                  start;
  logic                  clear;
  logic                  done;
  dims_t                 dims;
  operand_t              op_in;
  operand_t              op_head;
  buf_flags_t            op_flags;
  buf_flags_t            out_flags;
  logic                  op_pop;
  logic                  first;
  logic                  pipe_busy;
  acc_vec_t              acc;
  logic                  buf_push;
  logic                  buf_pop;
  logic [`MM_LANE_W-1:0] buf_lane;
  acc_t                  push_data;

  mm_cfg_regs i_cfg_regs (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .we_i       (cfg_we_i),
    .re_i       (cfg_re_i),
    .addr_i     (cfg_addr_i),
    .wdata_i    (cfg_wdata_i),
    .rdata_o    (cfg_rdata_o),
    .busy_i     (busy_o),
    .done_i     (done),
    .start_o    (start),
    .clear_o    (clear),
    .dims_o     (dims),
    .evt_done_o (evt_done_o)
  );

  // Operand word packing
  assign op_in.x    = op_x_i;
  assign op_in.w    = op_w_i;
  assign op_space_o = !op_flags.full;

  // Operand staging
  mm_fifo #(
    .T     (operand_t),
    .DEPTH (`MM_OP_DEPTH)
  ) i_op_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clear_i (clear),
    .push_i  (op_valid_i),
    .data_i  (op_in),
    .pop_i   (op_pop),
    .data_o  (op_head),
    .flags_o (op_flags)
  );

  mm_ctrl i_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear),
    .start_i     (start),
    .dims_i      (dims),
    .op_empty_i  (op_flags.empty),
    .pipe_busy_i (pipe_busy),
    .out_flags_i (out_flags),
    .op_pop_o    (op_pop),
    .first_o     (first),
    .buf_push_o  (buf_push),
    .buf_lane_o  (buf_lane),
    .buf_pop_o   (buf_pop),
    .busy_o      (busy_o),
    .done_o      (done)
  );

  // The popped operand enters the engine in the same cycle
  mm_engine i_engine (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear),
    .in_valid_i  (op_pop),
    .first_i     (first),
    .x_i         (op_head.x),
    .w_i         (op_head.w),
    .acc_o       (acc),
    .pipe_busy_o (pipe_busy)
  );

  // Lane chosen by the controller during buffering
  assign push_data = acc[buf_lane];

  // Output buffer, one row of results
  mm_fifo #(
    .T     (acc_t),
    .DEPTH (`MM_WIDTH)
  ) i_out_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clear_i (clear),
    .push_i  (buf_push),
    .data_i  (push_data),
    .pop_i   (buf_pop),
    .data_o  (z_data_o),
    .flags_o (out_flags)
  );

  assign z_valid_o = buf_pop;

endmodule

`default_nettype wire

//--- dv/tb_mm_top.sv
// Directed testbench for MM_OP_DEPTH of 4 and jobs of at most 64 operands
`timescale 1ns/1ps
`default_nettype none

`include "mm_defs.svh"

module tb_mm_top;

  import mm_pkg::*;

  localparam int MAX_OPS    = 64;
  localparam int WAIT_LIMIT = 1000;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  cfg_we_i;
  logic                  cfg_re_i;
  logic [`MM_ADDR_W-1:0] cfg_addr_i;
  logic [`MM_REG_W-1:0]  cfg_wdata_i;
  logic [`MM_REG_W-1:0]  cfg_rdata_o;
  logic                  op_valid_i;
  data_t                 op_x_i;
  w_vec_t                op_w_i;
  logic                  op_space_o;
  logic                  z_valid_o;
  acc_t                  z_data_o;
  logic                  busy_o;
  logic                  evt_done_o;

  integer seed = 1;
  int     done_cnt = 0;
  // Expected z words in row order with lane 0 first
  acc_t   exp_q[$];
  // Operands of the current job in row major order
  data_t  x_mem [MAX_OPS];
  w_vec_t w_mem [MAX_OPS];

  mm_top uut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_we_i    (cfg_we_i),
    .cfg_re_i    (cfg_re_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .op_valid_i  (op_valid_i),
    .op_x_i      (op_x_i),
    .op_w_i      (op_w_i),
    .op_space_o  (op_space_o),
    .z_valid_o   (z_valid_o),
    .z_data_o    (z_data_o),
    .busy_o      (busy_o),
    .evt_done_o  (evt_done_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      abort_run($sformatf("Mismatch at time %0t: %s is %0h, expected %0h",
                          $time, what, got, exp));
    end
  endtask

  // Every task starts and ends 1 ns after a rising edge
  task automatic next_edge();
    @(posedge clk_i);
    #1;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) next_edge();
  endtask

  task automatic cfg_write(input logic [`MM_ADDR_W-1:0] addr, input logic [`MM_REG_W-1:0] data);
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    next_edge();
    cfg_we_i = 1'b0;
  endtask

  // Read data is registered and shows up one edge after re
  task automatic cfg_read(input logic [`MM_ADDR_W-1:0] addr, output logic [`MM_REG_W-1:0] data);
    cfg_re_i   = 1'b1;
    cfg_addr_i = addr;
    next_edge();
    cfg_re_i = 1'b0;
    data     = cfg_rdata_o;
  endtask

  task automatic push_operand(input data_t x, input w_vec_t w);
    int waited;
    waited = 0;
    while (!op_space_o) begin
      waited++;
      assert (waited < WAIT_LIMIT) else begin
        abort_run("Timeout waiting for space in the operand buffer");
      end
      next_edge();
    end
    op_valid_i = 1'b1;
    op_x_i     = x;
    op_w_i     = w;
    next_edge();
    op_valid_i = 1'b0;
  endtask

  task automatic fill_random(input int n);
    for (int i = 0; i < n; i++) begin
      x_mem[i] = data_t'($random(seed));
      for (int j = 0; j < `MM_WIDTH; j++) begin
        w_mem[i][j] = data_t'($random(seed));
      end
    end
  endtask

  // Reference model sums x times w[j] over k and keeps ACC_W bits
  task automatic add_expected(input int m, input int k);
    acc_t sum;
    for (int r = 0; r < m; r++) begin
      for (int j = 0; j < `MM_WIDTH; j++) begin
        sum = '0;
        for (int i = 0; i < k; i++) begin
          sum = sum + acc_t'(x_mem[r*k+i]) * acc_t'(w_mem[r*k+i][j]);
        end
        exp_q.push_back(sum);
      end
    end
  endtask

  // The first pre operands go in before start and the rest follow random gaps up to gap_max
  task automatic run_job(input int m, input int k, input int pre, input int gap_max);
    int waited;
    int gap;
    int done_before;
    logic [`MM_REG_W-1:0] rdata;
    add_expected(m, k);
    cfg_write(`MM_REG_DIMS, {16'(m), 16'(k)});
    cfg_read(`MM_REG_DIMS, rdata);
    check_value("DIMS readback", rdata, {16'(m), 16'(k)});
    for (int i = 0; i < pre; i++) push_operand(x_mem[i], w_mem[i]);
    if (pre == `MM_OP_DEPTH) begin
      assert (!op_space_o) else abort_run("op_space_o stayed high with a full operand buffer");
    end
    done_before = done_cnt;
    cfg_write(`MM_REG_CTRL, 32'h1);
    check_value("busy_o after start", busy_o, 1);
    for (int i = pre; i < m * k; i++) begin
      if (gap_max > 0) begin
        gap = {$random(seed)} % (gap_max + 1);
        idle_cycles(gap);
      end
      push_operand(x_mem[i], w_mem[i]);
    end
    waited = 0;
    while (!evt_done_o) begin
      waited++;
      assert (waited < WAIT_LIMIT) else abort_run("Timeout waiting for evt_done_o");
      next_edge();
    end
    next_edge();
    check_value("done pulse count", done_cnt - done_before, 1);
    check_value("evt_done_o after done", evt_done_o, 0);
    check_value("busy_o after done", busy_o, 0);
    check_value("results not delivered", exp_q.size(), 0);
  endtask

  task automatic test_reset_state();
    logic [`MM_REG_W-1:0] rdata;
    check_value("busy_o", busy_o, 0);
    check_value("z_valid_o", z_valid_o, 0);
    check_value("evt_done_o", evt_done_o, 0);
    check_value("op_space_o", op_space_o, 1);
    cfg_read(`MM_REG_STATUS, rdata);
    check_value("STATUS after reset", rdata, 0);
  endtask

  // Large values also exercise the full 32 bit product
  task automatic test_single_row();
    x_mem[0] = 16'hFFFF;
    w_mem[0] = {16'hFFFF, 16'h1234, 16'h0002, 16'h0001};
    run_job(1, 1, 0, 0);
  endtask

  task automatic test_random_job();
    fill_random(15);
    run_job(3, 5, 0, 0);
  endtask

  task automatic test_prefill_gaps();
    fill_random(12);
    run_job(2, 6, `MM_OP_DEPTH, 5);
  endtask

  task automatic test_status_and_clear();
    logic [`MM_REG_W-1:0] rdata;
    cfg_read(`MM_REG_STATUS, rdata);
    check_value("STATUS sticky done", rdata, 32'h2);
    // Job that starves for operands and then gets cleared
    fill_random(`MM_OP_DEPTH);
    cfg_write(`MM_REG_DIMS, {16'd1, 16'd8});
    cfg_write(`MM_REG_CTRL, 32'h1);
    push_operand(x_mem[0], w_mem[0]);
    push_operand(x_mem[1], w_mem[1]);
    cfg_read(`MM_REG_STATUS, rdata);
    check_value("STATUS during job", rdata, 32'h1);
    cfg_write(`MM_REG_CTRL, 32'h2);
    check_value("busy_o after clear", busy_o, 0);
    // Operands staged while idle are dropped by the next clear
    for (int i = 0; i < `MM_OP_DEPTH; i++) push_operand(x_mem[i], w_mem[i]);
    check_value("op_space_o with staged operands", op_space_o, 0);
    cfg_write(`MM_REG_CTRL, 32'h2);
    check_value("op_space_o after clear", op_space_o, 1);
    cfg_read(`MM_REG_STATUS, rdata);
    check_value("STATUS after clear", rdata, 0);
    fill_random(6);
    run_job(2, 3, 1, 2);
    cfg_read(`MM_REG_STATUS, rdata);
    check_value("STATUS after fresh job", rdata, 32'h2);
  endtask

  // Monitor samples mid cycle where every output has settled
  always @(negedge clk_i) begin
    if (rst_ni === 1'b1) begin
      if (evt_done_o) done_cnt++;
      if (z_valid_o) begin
        if (exp_q.size() == 0) begin
          abort_run("An output word appeared while no result was expected");
        end else begin
          check_value("z_data_o", z_data_o, exp_q[0]);
          void'(exp_q.pop_front());
        end
      end
    end
  end

  initial begin
    rst_ni      = 1'b0;
    cfg_we_i    = 1'b0;
    cfg_re_i    = 1'b0;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    op_valid_i  = 1'b0;
    op_x_i      = '0;
    op_w_i      = '0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    next_edge();
    test_reset_state();
    test_single_row();
    test_random_job();
    test_prefill_gaps();
    test_status_and_clear();
    idle_cycles(4);
    if (exp_q.size() == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      abort_run("Some expected results were never produced");
    end
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+design
design/mm_pkg.sv
design/mm_fifo.sv
design/mm_cfg_regs.sv
design/mm_ctrl.sv
design/mm_engine.sv
design/mm_top.sv
dv/tb_mm_top.sv

//--- Bender.yml
package:
  name: mm_accel

sources:
  - include_dirs:
      - design
    files:
      - design/mm_pkg.sv
      - design/mm_fifo.sv
      - design/mm_cfg_regs.sv
      - design/mm_ctrl.sv
      - design/mm_engine.sv
      - design/mm_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/tb_mm_top.sv
